// File: rtl/sram_pkg.sv
package sram_pkg;

  localparam int DATA_W      = 16;  // bus word
  localparam int ADDR_W      = 16;  // master address
  localparam int SRAM_ADDR_W = 14;  // chip address pins
  localparam int INT_ADDR_W  = 8;   // internal ram index
  localparam int INT_WORDS   = 1 << INT_ADDR_W;
  localparam int NUM_BANKS   = 3;   // external chips on the shared bus
  localparam int REGION_W    = ADDR_W - SRAM_ADDR_W;

  // region 0 is the internal ram, regions 1..3 pick banks 0..2
  localparam logic [REGION_W-1:0] REGION_INTERNAL = '0;

  // bank controller states, same order as the old mem controller
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_WAIT        = 3'd0;
  localparam logic [STATE_W-1:0] ST_RD_SET_ADDR = 3'd1;
  localparam logic [STATE_W-1:0] ST_RD_DATA_GET = 3'd2;
  localparam logic [STATE_W-1:0] ST_RD_FINISH   = 3'd3;
  localparam logic [STATE_W-1:0] ST_WR_SET_ADDR = 3'd4;
  localparam logic [STATE_W-1:0] ST_WR_SET_WE   = 3'd5;
  localparam logic [STATE_W-1:0] ST_WR_FINISH   = 3'd6;

  // one address word, seen flat by the master or split by the decoder
  typedef union packed {
    logic [ADDR_W-1:0] word;
    struct packed {
      logic [REGION_W-1:0]    region;  // target select
      logic [SRAM_ADDR_W-1:0] offset;  // word inside the target
    } f;
  } mem_addr_u;

  typedef struct packed {
    logic              read_q;   // one cycle strobe
    logic              write_q;  // one cycle strobe
    mem_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_s;

  // pins of one chip, strobes are active low
  typedef struct packed {
    logic                   ce_n;
    logic                   oe_n;
    logic                   we_n;
    logic [SRAM_ADDR_W-1:0] addr;
  } bank_pins_s;

  typedef struct packed {
    logic              read_dn;
    logic              write_dn;
    logic [DATA_W-1:0] rdata;  // zero unless read_dn
  } unit_resp_s;

endpackage

// File: rtl/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder import sram_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_s req,
  input  logic     halt,
  output bus_req_s int_req,
  output bus_req_s bank_req [NUM_BANKS]
);

  logic              read_q_r;
  logic              write_q_r;
  mem_addr_u         addr_r;
  logic [DATA_W-1:0] wdata_r;
  logic              strobe;
  bus_req_s          req_r;
  logic [NUM_BANKS:0] tgt_hit;  // bit 0 internal, bit i+1 bank i

  // strobes are the control part, halt blocks them here and nowhere else
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_q_r  <= 1'b0;
      write_q_r <= 1'b0;
    end else begin
      read_q_r  <= req.read_q & ~halt;
      write_q_r <= req.write_q & ~halt;
    end
  end

  // address and data just follow the bus
  always_ff @(posedge clk) begin
    addr_r  <= req.addr;
    wdata_r <= req.wdata;
  end

  assign strobe = read_q_r | write_q_r;
  assign req_r  = {read_q_r, write_q_r, addr_r, wdata_r};

  // only the addressed target sees anything, the rest get zeros
  assign int_req    = tgt_hit[0] ? req_r : '0;
  assign tgt_hit[0] = strobe && (addr_r.f.region == REGION_INTERNAL);

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank_sel
    assign tgt_hit[i+1] = strobe && (addr_r.f.region == REGION_W'(i + 1));
    assign bank_req[i]  = tgt_hit[i+1] ? req_r : '0;
  end

  // master never asks for both at once
  a_single_strobe : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(req.read_q && req.write_q)
  );

endmodule

// File: rtl/internal_ram.sv
`timescale 1ns/1ns

module internal_ram import sram_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  bus_req_s   req,
  output unit_resp_s resp
);

  logic [DATA_W-1:0]     mem [INT_WORDS];  // no init, survives reset
  logic [INT_ADDR_W-1:0] idx;
  logic                  read_dn_r;
  logic                  write_dn_r;
  logic [DATA_W-1:0]     rdata_r;

  // low offset bits only, so upper offset bits alias
  assign idx = req.addr.f.offset[INT_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (req.write_q) begin
      mem[idx] <= req.wdata;
    end
  end

  // read word captured every cycle, qualified by read_dn below
  always_ff @(posedge clk) begin
    rdata_r <= mem[idx];
  end

  // done pulses one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_dn_r  <= 1'b0;
      write_dn_r <= 1'b0;
    end else begin
      read_dn_r  <= req.read_q;
      write_dn_r <= req.write_q;
    end
  end

  // idle unit returns zeros so the merge can or it in
  assign resp.read_dn  = read_dn_r;
  assign resp.write_dn = write_dn_r;
  assign resp.rdata    = read_dn_r ? rdata_r : '0;

endmodule

// File: rtl/sram_bank_ctrl.sv
`timescale 1ns/1ns

module sram_bank_ctrl import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_req_s          req,
  input  logic              halt,
  output bank_pins_s        pins,
  inout  wire  [DATA_W-1:0] sram_data,
  output unit_resp_s        resp
);

  logic [STATE_W-1:0]     state;
  logic [STATE_W-1:0]     state_nx;
  logic [SRAM_ADDR_W-1:0] addr_r;   // chip address for this transfer
  logic [DATA_W-1:0]      wdata_r;  // word to write
  logic                   accept;
  logic                   rd_active;
  logic                   wr_active;
  logic                   we_active;

  assign accept = (state == ST_WAIT) && (req.read_q || req.write_q);

  always_comb begin
    state_nx = state;
    if (halt) begin
      state_nx = ST_WAIT;  // abort, whatever we were doing
    end else begin
      case (state)
        ST_WAIT: begin
          if (req.read_q) begin
            state_nx = ST_RD_SET_ADDR;
          end else if (req.write_q) begin
            state_nx = ST_WR_SET_ADDR;
          end
        end
        ST_RD_SET_ADDR: state_nx = ST_RD_DATA_GET;
        ST_RD_DATA_GET: state_nx = ST_RD_FINISH;
        ST_RD_FINISH:   state_nx = ST_WAIT;
        ST_WR_SET_ADDR: state_nx = ST_WR_SET_WE;
        ST_WR_SET_WE:   state_nx = ST_WR_FINISH;
        ST_WR_FINISH:   state_nx = ST_WAIT;
        default:        state_nx = ST_WAIT;  // unused code 7
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_WAIT;
    end else begin
      state <= state_nx;
    end
  end

  // payload latched once per transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_r  <= req.addr.f.offset;
      wdata_r <= req.wdata;
    end
  end

  // halt drops the pins at once, the state follows on the next edge
  assign rd_active = !halt &&
                     ((state == ST_RD_SET_ADDR) || (state == ST_RD_DATA_GET));
  assign wr_active = !halt &&
                     ((state == ST_WR_SET_ADDR) || (state == ST_WR_SET_WE) ||
                      (state == ST_WR_FINISH));
  assign we_active = !halt && (state == ST_WR_SET_WE);  // we_n pulse in the middle

  assign pins.ce_n = ~(rd_active | wr_active);
  assign pins.oe_n = ~rd_active;
  assign pins.we_n = ~we_active;
  assign pins.addr = (rd_active || wr_active) ? addr_r : '0;  // zero when idle

  // own the shared data bus only while writing
  assign sram_data = wr_active ? wdata_r : 'z;

  // done goes out combinationally, the merge registers it
  assign resp.read_dn  = !halt && (state == ST_RD_DATA_GET);
  assign resp.write_dn = !halt && (state == ST_WR_FINISH);
  assign resp.rdata    = resp.read_dn ? sram_data : '0;  // chip output sampled here

  // address must be set up a cycle before the write pulse
  a_we_inside_ce : assert property (
    @(posedge clk) disable iff (!rst_n)
    !pins.we_n |-> !pins.ce_n && !$past(pins.ce_n)
  );

endmodule

// File: rtl/bus_response_merge.sv
`timescale 1ns/1ns

module bus_response_merge import sram_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  unit_resp_s             int_resp,
  input  unit_resp_s             bank_resp [NUM_BANKS],
  input  bank_pins_s             bank_pins [NUM_BANKS],
  output logic [SRAM_ADDR_W-1:0] sram_addr,
  output logic                   sram_oe_n,
  output logic                   sram_we_n,
  output unit_resp_s             resp
);

  unit_resp_s           resp_or;
  logic [NUM_BANKS-1:0] ce_n_vec;  // only for the bus check

  // idle banks give zero address and high strobes
  always_comb begin
    sram_addr = '0;
    sram_oe_n = 1'b1;
    sram_we_n = 1'b1;
    resp_or   = int_resp;
    for (int i = 0; i < NUM_BANKS; i++) begin
      sram_addr   = sram_addr | bank_pins[i].addr;
      sram_oe_n   = sram_oe_n & bank_pins[i].oe_n;  // and of active lows
      sram_we_n   = sram_we_n & bank_pins[i].we_n;
      resp_or     = resp_or | bank_resp[i];
      ce_n_vec[i] = bank_pins[i].ce_n;
    end
  end

  // one register stage toward the master
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp <= '0;
    end else begin
      resp <= resp_or;
    end
  end

  a_one_done : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(resp.read_dn && resp.write_dn)
  );

  // shared address and data bus, so at most one chip enabled
  a_one_chip : assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(~ce_n_vec) <= 1
  );

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top import sram_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  bus_req_s               req,
  input  logic                   halt,
  output logic                   read_dn,
  output logic                   write_dn,
  output logic [DATA_W-1:0]      rdata,
  output logic [SRAM_ADDR_W-1:0] sram_addr,
  inout  wire  [DATA_W-1:0]      sram_data,
  output logic [NUM_BANKS-1:0]   sram_ce_n,
  output logic                   sram_oe_n,
  output logic                   sram_we_n
);

  bus_req_s   int_req;
  bus_req_s   bank_req [NUM_BANKS];
  unit_resp_s int_resp;
  unit_resp_s bank_resp [NUM_BANKS];
  bank_pins_s bank_pins [NUM_BANKS];
  unit_resp_s resp;  // merged and registered

  bus_decoder u_decoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .halt     (halt),
    .int_req  (int_req),
    .bank_req (bank_req)
  );

  internal_ram u_int_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (int_req),
    .resp  (int_resp)
  );

  // one controller per chip, all on the same data bus
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    sram_bank_ctrl u_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (bank_req[i]),
      .halt      (halt),
      .pins      (bank_pins[i]),
      .sram_data (sram_data),
      .resp      (bank_resp[i])
    );

    assign sram_ce_n[i] = bank_pins[i].ce_n;  // private enable per chip
  end

  bus_response_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .int_resp  (int_resp),
    .bank_resp (bank_resp),
    .bank_pins (bank_pins),
    .sram_addr (sram_addr),
    .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n),
    .resp      (resp)
  );

  assign read_dn  = resp.read_dn;
  assign write_dn = resp.write_dn;
  assign rdata    = resp.rdata;

endmodule

// File: test/sram_chip_model.sv
`timescale 1ns/1ns

module sram_chip_model import sram_pkg::*; (
  input  logic                   ce_n,
  input  logic                   oe_n,
  input  logic                   we_n,
  input  logic [SRAM_ADDR_W-1:0] addr,
  inout  wire  [DATA_W-1:0]      data
);

  logic [DATA_W-1:0] mem [1 << SRAM_ADDR_W];  // power-up contents unknown

  // word lands on the rising edge of we_n, chip selected
  always @(posedge we_n) begin
    if (ce_n === 1'b0) begin
      mem[addr] <= data;
    end
  end

  // output buffer on only for a selected read
  assign data = (ce_n === 1'b0 && oe_n === 1'b0 && we_n === 1'b1) ? mem[addr] : 'z;

endmodule

// File: test/tb_entry.svh
`ifndef TB_ENTRY_SVH
`define TB_ENTRY_SVH

typedef enum logic [1:0] {
  OP_WR      = 2'd0,
  OP_RD      = 2'd1,
  OP_WR_HELD = 2'd2,  // strobe issued while halt is already high
  OP_RD_HELD = 2'd3
} test_op_e;

// one row of the stimulus table
typedef struct packed {
  test_op_e    op;
  logic [15:0] addr;       // flat bus address, region in the top two bits
  logic [15:0] wdata;
  logic [15:0] exp_rdata;  // reads only
  logic [3:0]  halt_at;    // cycles after the strobe, 0 for none
} test_entry_s;

`endif

// File: test/tb_checker.sv
`timescale 1ns/1ns
`include "tb_entry.svh"

module tb_checker import sram_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   halt,
  input  logic                   start,   // high in the strobe cycle
  input  test_entry_s            entry,
  input  logic                   report,
  input  logic                   read_dn,
  input  logic                   write_dn,
  input  logic [DATA_W-1:0]      rdata,
  input  logic [SRAM_ADDR_W-1:0] sram_addr,
  input  logic [NUM_BANKS-1:0]   sram_ce_n,
  input  logic                   sram_oe_n,
  input  logic                   sram_we_n,
  output logic                   busy,
  output int                     errors
);

  localparam int WINDOW = 10;  // cycles watched for a done pulse

  test_entry_s       cur;
  int                cyc;           // negedges since the strobe
  int                test_id;
  int                test_errs;
  int                tests_failed;
  bit                reset_checked;
  bit                expect_done;
  bit                done_seen;
  logic [DATA_W-1:0] int_ref [INT_WORDS];  // aliases on 8 bits like the RAM
  bit                int_known [INT_WORDS];
  logic [DATA_W-1:0] bank_ref [logic [ADDR_W-1:0]];  // keyed by region and offset

  initial begin
    busy          = 1'b0;
    errors        = 0;
    test_id       = 0;
    tests_failed  = 0;
    reset_checked = 1'b0;
  end

  task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s exp %h act %h in test %0d", name, exp, act, test_id);
      test_errs++;
      errors++;
    end
  endtask

  task automatic note_problem(input string what);
    $display("test %0d: %s", test_id, what);
    test_errs++;
    errors++;
  endtask

  task automatic close_test(input string label);
    $display("test %0d %s: %s", test_id, label, (test_errs != 0) ? "failed" : "ok");
    if (test_errs != 0) tests_failed++;
    test_id++;
    busy = 1'b0;
  endtask

  // only the addressed chip may be enabled, never under halt
  task automatic watch_pins();
    logic [NUM_BANKS-1:0] ce_exp;
    logic [1:0]           region;
    region = cur.addr[15:14];
    ce_exp = '1;
    if (region != REGION_INTERNAL) ce_exp[region - 1] = 1'b0;
    if (halt) begin
      if (sram_ce_n != '1 || !sram_oe_n || !sram_we_n)
        note_problem("SRAM strobes still active while halt is high");
    end else if (sram_ce_n != '1) begin
      if (cur.op == OP_WR_HELD || cur.op == OP_RD_HELD || region == REGION_INTERNAL) begin
        note_problem("a chip enable went low for a transfer that reaches no chip");
      end else begin
        compare_word("sram_ce_n", 16'(ce_exp), 16'(sram_ce_n));
        compare_word("sram_addr", 16'(cur.addr[13:0]), 16'(sram_addr));
      end
    end
    if (cur.op == OP_WR && !sram_oe_n) note_problem("sram_oe_n went low during a write");
    if (!read_dn) compare_word("rdata", '0, rdata);  // zero outside read_dn
  endtask

  task automatic take_done();
    logic [15:0] exp_lat;
    bit          known;
    logic [15:0] ref_val;
    exp_lat = (cur.addr[15:14] == REGION_INTERNAL) ? 16'd3 : ((cur.op == OP_WR) ? 16'd5 : 16'd4);
    done_seen = 1'b1;
    known = 1'b0;
    ref_val = '0;
    if (!expect_done) begin
      note_problem($sformatf("unexpected done pulse %0d cycles after the strobe", cyc));
    end else if (cur.op == OP_WR) begin
      compare_word("write_dn", 16'd1, 16'(write_dn));
      compare_word("read_dn", 16'd0, 16'(read_dn));
      compare_word("write_dn delay", exp_lat, 16'(cyc));
      if (cur.addr[15:14] == REGION_INTERNAL) begin
        int_ref[cur.addr[7:0]]   = cur.wdata;
        int_known[cur.addr[7:0]] = 1'b1;
      end else begin
        bank_ref[cur.addr] = cur.wdata;
      end
    end else begin
      compare_word("read_dn", 16'd1, 16'(read_dn));
      compare_word("write_dn", 16'd0, 16'(write_dn));
      compare_word("read_dn delay", exp_lat, 16'(cyc));
      compare_word("rdata", cur.exp_rdata, rdata);
      if (cur.addr[15:14] == REGION_INTERNAL) begin
        known   = int_known[cur.addr[7:0]];
        ref_val = int_ref[cur.addr[7:0]];
      end else if (bank_ref.exists(cur.addr)) begin
        known   = 1'b1;
        ref_val = bank_ref[cur.addr];
      end
      if (known) compare_word("rdata (reference memory)", ref_val, rdata);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (!reset_checked) begin  // first quiet cycle after reset
        test_errs = 0;
        compare_word("read_dn", '0, 16'(read_dn));
        compare_word("write_dn", '0, 16'(write_dn));
        compare_word("rdata", '0, rdata);
        compare_word("sram_ce_n", 16'h7, 16'(sram_ce_n));
        compare_word("sram_oe_n", 16'h1, 16'(sram_oe_n));
        compare_word("sram_we_n", 16'h1, 16'(sram_we_n));
        reset_checked = 1'b1;
        close_test("reset");
      end
      if (start) begin
        cur         = entry;
        cyc         = 0;
        test_errs   = 0;
        done_seen   = 1'b0;
        busy        = 1'b1;
        expect_done = (entry.op == OP_WR || entry.op == OP_RD) && entry.halt_at == 0;
      end else if (busy) begin
        cyc++;
      end
      if (busy) begin
        watch_pins();
        if (read_dn || write_dn) take_done();
        if (expect_done && done_seen) begin
          close_test($sformatf("%s addr %h", cur.op.name(), cur.addr));
        end else if (cyc >= WINDOW) begin
          if (expect_done) note_problem("no done pulse within 10 cycles");
          close_test($sformatf("%s addr %h halt %0d", cur.op.name(), cur.addr, cur.halt_at));
        end
      end
    end
  end

  always @(posedge report) begin
    $display("tests %0d  passed %0d  failed %0d  errors %0d",
             test_id, test_id - tests_failed, tests_failed, errors);
  end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ns
`include "tb_entry.svh"

module tb_top import sram_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_DIRECTED = 25;
  localparam int NUM_PAIRS    = 40;  // random write then read
  localparam int NUM_TESTS    = NUM_DIRECTED + 2 * NUM_PAIRS;
  localparam int TIMEOUT_NS   = 2 * NUM_TESTS * 8 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n;
  bus_req_s               req;
  logic                   halt;
  logic                   read_dn;
  logic                   write_dn;
  logic [DATA_W-1:0]      rdata;
  logic [SRAM_ADDR_W-1:0] sram_addr;
  wire  [DATA_W-1:0]      sram_data;  // shared by the bank ctrls and all chips
  logic [NUM_BANKS-1:0]   sram_ce_n;
  logic                   sram_oe_n;
  logic                   sram_we_n;
  test_entry_s            stim [NUM_DIRECTED];
  test_entry_s            cur_entry;
  logic                   start;
  logic                   report;
  logic                   chk_busy;
  int                     chk_errors;
  int                     seed;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  mem_subsystem_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .halt      (halt),
    .read_dn   (read_dn),
    .write_dn  (write_dn),
    .rdata     (rdata),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_ce_n (sram_ce_n),
    .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_chip
    sram_chip_model u_chip (
      .ce_n (sram_ce_n[i]),  // own enable, rest shared
      .oe_n (sram_oe_n),
      .we_n (sram_we_n),
      .addr (sram_addr),
      .data (sram_data)
    );
  end

  tb_checker u_chk (
    .clk (clk), .rst_n (rst_n), .halt (halt), .start (start), .entry (cur_entry),
    .report (report), .read_dn (read_dn), .write_dn (write_dn), .rdata (rdata),
    .sram_addr (sram_addr), .sram_ce_n (sram_ce_n), .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n), .busy (chk_busy), .errors (chk_errors)
  );

  // op, addr, wdata, expected rdata, halt cycle
  task automatic fill_stimulus();
    stim[0]  = {OP_WR, 16'h0012, 16'ha5c3, 16'h0000, 4'd0};  // internal ram
    stim[1]  = {OP_RD, 16'h0012, 16'h0000, 16'ha5c3, 4'd0};
    stim[2]  = {OP_WR, 16'h0112, 16'h1234, 16'h0000, 4'd0};  // offset bit 8 aliases
    stim[3]  = {OP_RD, 16'h0012, 16'h0000, 16'h1234, 4'd0};
    stim[4]  = {OP_WR, 16'h4123, 16'hbeef, 16'h0000, 4'd0};  // bank 0
    stim[5]  = {OP_RD, 16'h4123, 16'h0000, 16'hbeef, 4'd0};
    stim[6]  = {OP_WR, 16'h8123, 16'h0f0f, 16'h0000, 4'd0};  // bank 1, same offset
    stim[7]  = {OP_RD, 16'h8123, 16'h0000, 16'h0f0f, 4'd0};
    stim[8]  = {OP_WR, 16'hc123, 16'h7e57, 16'h0000, 4'd0};  // bank 2
    stim[9]  = {OP_RD, 16'hc123, 16'h0000, 16'h7e57, 4'd0};
    stim[10] = {OP_RD, 16'h4123, 16'h0000, 16'hbeef, 4'd0};
    stim[11] = {OP_RD, 16'h8123, 16'h0000, 16'h0f0f, 4'd0};
    stim[12] = {OP_WR, 16'hffff, 16'h55aa, 16'h0000, 4'd0};  // top offset
    stim[13] = {OP_RD, 16'hffff, 16'h0000, 16'h55aa, 4'd0};
    stim[14] = {OP_WR, 16'h4123, 16'hdead, 16'h0000, 4'd2};  // aborted in set address
    stim[15] = {OP_RD, 16'h4123, 16'h0000, 16'hbeef, 4'd0};
    stim[16] = {OP_WR, 16'h8123, 16'hdead, 16'h0000, 4'd1};  // aborted before start
    stim[17] = {OP_RD, 16'h8123, 16'h0000, 16'h0f0f, 4'd0};
    stim[18] = {OP_RD, 16'hc123, 16'h0000, 16'h0000, 4'd3};  // aborted in data get
    stim[19] = {OP_RD, 16'hc123, 16'h0000, 16'h0000, 4'd2};
    stim[20] = {OP_RD, 16'hc123, 16'h0000, 16'h7e57, 4'd0};
    stim[21] = {OP_WR_HELD, 16'h4123, 16'h0bad, 16'h0000, 4'd0};
    stim[22] = {OP_RD_HELD, 16'h8123, 16'h0000, 16'h0000, 4'd0};
    stim[23] = {OP_RD, 16'h4123, 16'h0000, 16'hbeef, 4'd0};
    stim[24] = {OP_RD, 16'h8123, 16'h0000, 16'h0f0f, 4'd0};
  endtask

  // strobe for one cycle, halt as the entry says, then wait for the checker
  task automatic run_entry(input test_entry_s e);
    int cyc;
    bit held;
    held = (e.op == OP_WR_HELD) || (e.op == OP_RD_HELD);
    cyc  = 0;
    @(posedge clk);
    #2;
    cur_entry     = e;
    start         = 1'b1;
    req.read_q    = (e.op == OP_RD) || (e.op == OP_RD_HELD);
    req.write_q   = (e.op == OP_WR) || (e.op == OP_WR_HELD);
    req.addr.word = e.addr;
    req.wdata     = e.wdata;
    halt          = held;
    while (cyc == 0 || chk_busy || halt) begin
      @(posedge clk);
      #2;
      cyc++;
      start       = 1'b0;
      req.read_q  = 1'b0;
      req.write_q = 1'b0;
      if (cyc == e.halt_at) halt = 1'b1;
      if ((held && cyc == 2) || (e.halt_at != 0 && cyc == e.halt_at + 2)) halt = 1'b0;
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    rst_n     = 1'b0;
    halt      = 1'b0;
    req       = '0;
    start     = 1'b0;
    report    = 1'b0;
    cur_entry = '0;
    seed      = 56992;
    void'($urandom(seed));
    fill_stimulus();
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      run_entry(stim[i]);
    end
    for (int i = 0; i < NUM_PAIRS; i++) begin
      addr        = $urandom;
      addr[15:14] = 2'(i % 4);  // every region in turn
      data        = $urandom;
      run_entry({OP_WR, addr, data, 16'h0000, 4'd0});
      run_entry({OP_RD, addr, 16'h0000, data, 4'd0});
    end
    @(posedge clk);
    #2 report = 1'b1;
    @(negedge clk);
    if (chk_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+test
rtl/sram_pkg.sv
rtl/bus_decoder.sv
rtl/internal_ram.sv
rtl/sram_bank_ctrl.sv
rtl/bus_response_merge.sv
rtl/mem_subsystem_top.sv
test/sram_chip_model.sv
test/tb_checker.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - rtl/sram_pkg.sv
  - rtl/bus_decoder.sv
  - rtl/internal_ram.sv
  - rtl/sram_bank_ctrl.sv
  - rtl/bus_response_merge.sv
  - rtl/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/sram_chip_model.sv
      - test/tb_checker.sv
      - test/tb_top.sv
